/* bench/tb_time_sync.sv */
`timescale 1ns/1ps

module tb_time_sync
   import time_sync_reg_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int MAX_CASES  = 64;
   localparam int MEM_AW     = 8;
   localparam int ACK_LIMIT  = 16;

   localparam logic [31:0] OP_END        = 32'd0;
   localparam logic [31:0] OP_WRITE      = 32'd1;
   localparam logic [31:0] OP_READ       = 32'd2;
   localparam logic [31:0] OP_PPS        = 32'd3;
   localparam logic [31:0] OP_WAIT       = 32'd4;
   localparam logic [31:0] OP_INT_PERIOD = 32'd5;
   localparam logic [31:0] OP_STEP_CHECK = 32'd6;

   logic              sys_clk;
   logic              rst;
   logic              cyc;
   logic              stb;
   logic              we;
   logic [ADDR_W-1:0] adr;
   logic [TIME_W-1:0] wdata;
   logic [TIME_W-1:0] rdata;
   logic              ack;
   logic              pps_pos;
   logic              pps_neg;
   logic              link;
   logic [TIME_W-1:0] master_time;
   logic              int_irq;
   logic              epoch;
   logic              pps_out;

   // each case takes four words of opcode, address, data and expected value
   logic [31:0] cases_mem [0:(1 << MEM_AW)-1];
   int          num_cases;
   longint      watch_ns;

   // the link output feeds straight back into the receiver
   time_sync time_sync_i (
      .sys_clk_i     (sys_clk),
      .rst_i         (rst),
      .cyc_i         (cyc),
      .stb_i         (stb),
      .we_i          (we),
      .adr_i         (adr),
      .dat_i         (wdata),
      .dat_o         (rdata),
      .ack_o         (ack),
      .pps_posedge_i (pps_pos),
      .pps_negedge_i (pps_neg),
      .exp_pps_in_i  (link),
      .exp_pps_out_o (link),
      .master_time_o (master_time),
      .int_o         (int_irq),
      .epoch_o       (epoch),
      .pps_o         (pps_out)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, want));
   endtask

   // every task starts and ends 1 ns after a rising edge
   task automatic step_cycle();
      @(posedge sys_clk);
      #1;
   endtask

   function automatic logic [31:0] case_word(input int idx, input int field);
      return cases_mem[MEM_AW'(4 * idx + field)];
   endfunction

   function automatic int case_budget(input logic [31:0] op, input logic [31:0] data,
                                      input logic [31:0] expected);
      if (op == OP_WAIT || op == OP_STEP_CHECK)
         return int'(data) + 8;
      if (op == OP_INT_PERIOD)
         return 4 * (int'(expected) + ACK_LIMIT);
      return 4 * ACK_LIMIT;
   endfunction

   task automatic bus_cycle(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [TIME_W-1:0] data, output logic [TIME_W-1:0] got);
      int waited;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = addr;
      wdata = data;
      waited = 1;
      step_cycle();
      while (!ack)
      begin
         step_cycle();
         waited++;
         if (waited > ACK_LIMIT)
            fail_run("no Wishbone acknowledge arrived within the cycle limit");
      end
      got = rdata;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      step_cycle();
   endtask

   task automatic wait_int(input int limit, output int cycles);
      cycles = 1;
      step_cycle();
      while (!int_irq)
      begin
         step_cycle();
         cycles++;
         if (cycles > limit)
            fail_run("int_o did not pulse within the expected interval");
      end
   endtask

   task automatic check_int_period(input logic [31:0] period);
      int                gap;
      int                limit;
      logic [TIME_W-1:0] first_tick;
      logic [TIME_W-1:0] second_tick;
      logic [TIME_W-1:0] unused;
      limit = 2 * int'(period) + 8;
      // the first pulse only aligns to the tick stream
      wait_int(limit, gap);
      wait_int(limit, gap);
      assert (gap == period)
         else report_mismatch("int_o period", 32'(gap), period);
      bus_cycle(1'b0, ADDR_TICK_TIME, '0, first_tick);
      wait_int(limit, gap);
      bus_cycle(1'b0, ADDR_TICK_TIME, '0, second_tick);
      unused = second_tick - first_tick;
      assert (unused === period)
         else report_mismatch("tick_time difference", unused, period);
   endtask

   // the input is first sampled high on cycle 1, time clears on cycle 3 when armed
   task automatic pps_pulse(input logic use_posedge, input logic armed);
      logic [TIME_W-1:0] expect_time;
      logic              expect_epoch;
      int                n;
      expect_time = master_time;
      if (use_posedge)
         pps_pos = 1'b1;
      else
         pps_neg = 1'b1;
      for (n = 1; n <= 6; n++)
      begin
         step_cycle();
         if (n == 2)
         begin
            pps_pos = 1'b0;
            pps_neg = 1'b0;
         end
         expect_time = (armed && n == 3) ? '0 : expect_time + 32'd1;
         assert (master_time === expect_time)
            else report_mismatch("master_time_o", master_time, expect_time);
         assert (pps_out === (n == 3))
            else report_mismatch("pps_o", 32'(pps_out), 32'(n == 3));
         // epoch rises only on the cycle after time was cleared to zero
         expect_epoch = armed && (n == 4);
         assert (epoch === expect_epoch)
            else report_mismatch("epoch_o", 32'(epoch), 32'(expect_epoch));
      end
   endtask

   task automatic check_steps(input logic [31:0] cycles, input logic [TIME_W-1:0] delta);
      logic [TIME_W-1:0] last_time;
      logic [TIME_W-1:0] step;
      int                syncs;
      int                n;
      syncs = 0;
      for (n = 0; n < int'(cycles); n++)
      begin
         last_time = master_time;
         step_cycle();
         step = master_time - last_time;
         if (step != 32'd1)
         begin
            assert (step === delta + 32'd1)
               else report_mismatch("master_time_o step", step, delta + 32'd1);
            syncs++;
         end
      end
      if (delta != '0)
      begin
         assert (syncs > 0)
            else fail_run("no external sync step was seen on master_time_o");
      end
   endtask

   initial
   begin
      wait (watch_ns != 0);
      #(watch_ns);
      fail_run("watchdog expired before all cases finished");
   end

   initial
   begin
      logic [31:0]       op_w;
      logic [31:0]       adr_w;
      logic [31:0]       data_w;
      logic [31:0]       exp_w;
      logic [TIME_W-1:0] got;
      int                longest;
      int                idx;
      rst      = 1'b1;
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      wdata    = '0;
      pps_pos  = 1'b0;
      pps_neg  = 1'b0;
      watch_ns = 0;
      $readmemh("bench/time_sync_cases.txt", cases_mem);
      num_cases = 0;
      longest   = 0;
      while (num_cases < MAX_CASES && case_word(num_cases, 0) != OP_END)
      begin
         if (case_budget(case_word(num_cases, 0), case_word(num_cases, 2),
                         case_word(num_cases, 3)) > longest)
            longest = case_budget(case_word(num_cases, 0), case_word(num_cases, 2),
                                  case_word(num_cases, 3));
         num_cases++;
      end
      if (num_cases == 0 || num_cases == MAX_CASES)
         fail_run("case file is empty or has no end marker");
      watch_ns = longint'(num_cases * longest + 16) * CLK_PERIOD;

      repeat (3) @(posedge sys_clk);
      #1;
      rst = 1'b0;

      for (idx = 0; idx < num_cases; idx++)
      begin
         op_w   = case_word(idx, 0);
         adr_w  = case_word(idx, 1);
         data_w = case_word(idx, 2);
         exp_w  = case_word(idx, 3);
         case (op_w)
            OP_WRITE:      bus_cycle(1'b1, adr_w[ADDR_W-1:0], data_w, got);
            OP_READ:
            begin
               bus_cycle(1'b0, adr_w[ADDR_W-1:0], '0, got);
               assert (got === exp_w)
                  else report_mismatch("dat_o", got, exp_w);
            end
            OP_PPS:        pps_pulse(data_w[0], exp_w[0]);
            OP_WAIT:       repeat (data_w) step_cycle();
            OP_INT_PERIOD: check_int_period(exp_w);
            OP_STEP_CHECK: check_steps(data_w, exp_w);
            default:       fail_run($sformatf("unknown opcode %0h in case %0d", op_w, idx));
         endcase
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

/* bench/time_sync_cases.txt */
// columns: opcode address data expected (hex); opcodes 0 end, 1 write, 2 read check,
// 3 pps (data 1 = posedge input, expected 1 = armed), 4 wait, 5 int period, 6 step check
2 0 0 0            // control after reset
2 1 0 1869F        // interval after reset
2 2 0 0            // delta after reset
2 3 0 0            // arm is write only
2 7 0 0            // unmapped word
1 1 13 0
2 1 0 13
1 2 5A5A5A5A 0
2 2 0 5A5A5A5A
1 2 0 0
2 2 0 0
1 0 2 0            // interrupts on, interval ticks
2 0 0 2
5 0 0 14           // ticks every 20 cycles
1 0 8 0            // pps from the posedge input
3 0 1 0            // not armed, time runs on
1 3 0 0
3 0 1 1
1 0 0 0            // pps from the negedge input
1 3 0 0
3 0 0 1
4 0 64 0
1 1 2F 0           // frames every 48 cycles
1 0 4 0            // external sync from the loop back
6 0 190 0
1 2 100 0
6 0 190 100
1 0 0 0
0 0 0 0

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --top-module tb_time_sync -f time_sync.f -o tb_time_sync_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_time_sync_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Finished with no errors$" "$log"; then
   exit 0
fi
exit 1

/* src/master_clock.sv */
`timescale 1ns/1ps

module master_clock
   import time_sync_reg_pkg::*;
(
   input  logic               sys_clk_i,
   input  logic               rst_i,
   time_sync_cfg_if.clock_dst cfg,
   input  logic               pps_ext_i,
   input  logic               internal_tick_i,
   input  logic               sync_rcvd_i,
   input  logic [TIME_W-1:0]  rcvd_time_i,
   output logic [TIME_W-1:0]  master_time_o,
   output logic [TIME_W-1:0]  tick_time_o,
   output logic               epoch_o,
   output logic               int_o
);

   logic sync_armed_q;

   // a sync from the peer wins over a pending PPS clear
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         master_time_o <= '0;
      else if (cfg.external_sync && sync_rcvd_i)
         master_time_o <= rcvd_time_i + cfg.delta_time;
      else if (sync_armed_q && pps_ext_i)
         master_time_o <= '0;
      else
         master_time_o <= master_time_o + 1'b1;
   end

   // software arms once and the next PPS edge consumes it
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         sync_armed_q <= 1'b0;
      else if (cfg.arm_sync)
         sync_armed_q <= 1'b1;
      else if (sync_armed_q && pps_ext_i)
         sync_armed_q <= 1'b0;
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (internal_tick_i)
         tick_time_o <= master_time_o;
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         epoch_o <= 1'b0;
         int_o   <= 1'b0;
      end
      else
      begin
         epoch_o <= (master_time_o[EPOCH_BITS-1:0] == '0);
         int_o   <= internal_tick_i & cfg.tick_int_enable;
      end
   end

endmodule

/* src/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer
   import time_sync_reg_pkg::*;
(
   input  logic               sys_clk_i,
   input  logic               rst_i,
   input  logic               pps_posedge_i,
   input  logic               pps_negedge_i,
   time_sync_cfg_if.timer_dst cfg,
   output logic               pps_ext_o,
   output logic               internal_tick_o,
   output logic               pps_o
);

   logic [TIME_W-1:0] count_q;
   logic              tick_free_run;
   logic              pps_in_q;
   logic              pps_prev_q;

   // counts 0 up to the interval, so ticks are interval+1 cycles apart
   assign tick_free_run = (count_q >= cfg.tick_interval);

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i || tick_free_run)
         count_q <= '0;
      else
         count_q <= count_q + 1'b1;
   end

   // pps_edge picks which of the two board inputs carries the pulse
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         pps_in_q        <= 1'b0;
         pps_prev_q      <= 1'b0;
         pps_ext_o       <= 1'b0;
         pps_o           <= 1'b0;
         internal_tick_o <= 1'b0;
      end
      else
      begin
         pps_in_q        <= cfg.pps_edge ? pps_posedge_i : pps_negedge_i;
         pps_prev_q      <= pps_in_q;
         pps_ext_o       <= pps_in_q & ~pps_prev_q;
         pps_o           <= pps_ext_o;
         internal_tick_o <= cfg.tick_source ? pps_ext_o : tick_free_run;
      end
   end

   pps_ext_single: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      pps_ext_o |=> !pps_ext_o);

endmodule

/* src/time_link_pkg.sv */
package time_link_pkg;

   // one start bit followed by the time word, MSB first, one bit per clock
   localparam int FRAME_BITS = 33;
   localparam int DATA_BITS  = FRAME_BITS - 1;
   localparam int CNT_W      = $clog2(DATA_BITS);

   // the line idles at the opposite level
   localparam logic START_BIT = 1'b1;

   // cycles from the sender capturing master time to the receiver's word being
   // loaded into master time: one cycle in START, the start bit, the data bits,
   // the receiver's sync register and the load itself
   // the sender adds this so a looped back word lands without a jump
   localparam int unsigned LINK_LATENCY = FRAME_BITS + 3;

endpackage

/* src/time_receiver.sv */
`timescale 1ns/1ps

module time_receiver
   import time_link_pkg::*;
(
   input  logic                 sys_clk_i,
   input  logic                 rst_i,
   input  logic                 exp_pps_in_i,
   output logic [DATA_BITS-1:0] rcvd_time_o,
   output logic                 sync_rcvd_o
);

   logic             busy_q;
   logic [CNT_W-1:0] bit_cnt_q;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         busy_q      <= 1'b0;
         bit_cnt_q   <= '0;
         sync_rcvd_o <= 1'b0;
      end
      else
      begin
         sync_rcvd_o <= 1'b0;
         if (!busy_q)
         begin
            if (exp_pps_in_i == START_BIT)
            begin
               busy_q    <= 1'b1;
               bit_cnt_q <= '0;
            end
         end
         else
         begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            // last data bit is sampled on this edge
            if (bit_cnt_q == CNT_W'(DATA_BITS - 1))
            begin
               busy_q      <= 1'b0;
               sync_rcvd_o <= 1'b1;
            end
         end
      end
   end

   // the shift register doubles as the output word, complete when the pulse rises
   always_ff @(posedge sys_clk_i)
   begin
      if (busy_q)
         rcvd_time_o <= {rcvd_time_o[DATA_BITS-2:0], exp_pps_in_i};
   end

   sync_pulse_single: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      sync_rcvd_o |=> !sync_rcvd_o);

endmodule

/* src/time_sender.sv */
`timescale 1ns/1ps

module time_sender
   import time_link_pkg::*;
(
   input  logic                 sys_clk_i,
   input  logic                 rst_i,
   input  logic [DATA_BITS-1:0] master_time_i,
   input  logic                 send_sync_i,
   output logic                 exp_pps_out_o
);

   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA
   } state_t;

   state_t               state_q;
   logic [CNT_W-1:0]     bit_cnt_q;
   logic [DATA_BITS-1:0] shift_q;

   // ticks that arrive while a frame is on the line are ignored
   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         state_q       <= IDLE;
         bit_cnt_q     <= '0;
         exp_pps_out_o <= ~START_BIT;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               exp_pps_out_o <= ~START_BIT;
               if (send_sync_i)
                  state_q <= START;
            end
            START:
            begin
               exp_pps_out_o <= START_BIT;
               bit_cnt_q     <= '0;
               state_q       <= DATA;
            end
            DATA:
            begin
               exp_pps_out_o <= shift_q[DATA_BITS-1];
               bit_cnt_q     <= bit_cnt_q + 1'b1;
               if (bit_cnt_q == CNT_W'(DATA_BITS - 1))
                  state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // the word is sent ahead by the link delay so it is current on arrival
   always_ff @(posedge sys_clk_i)
   begin
      if (state_q == IDLE && send_sync_i)
         shift_q <= master_time_i + DATA_BITS'(LINK_LATENCY);
      else if (state_q == DATA)
         shift_q <= {shift_q[DATA_BITS-2:0], 1'b0};
   end

endmodule

/* src/time_sync.sv */
`timescale 1ns/1ps

module time_sync
   import time_sync_reg_pkg::*;
(
   input  logic              sys_clk_i,
   input  logic              rst_i,
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] adr_i,
   input  logic [TIME_W-1:0] dat_i,
   output logic [TIME_W-1:0] dat_o,
   output logic              ack_o,
   input  logic              pps_posedge_i,
   input  logic              pps_negedge_i,
   input  logic              exp_pps_in_i,
   output logic              exp_pps_out_o,
   output logic [TIME_W-1:0] master_time_o,
   output logic              int_o,
   output logic              epoch_o,
   output logic              pps_o
);

   logic [TIME_W-1:0] tick_time;
   logic [TIME_W-1:0] rcvd_time;
   logic              sync_rcvd;
   logic              pps_ext;
   logic              internal_tick;

   time_sync_cfg_if cfg_bus ();

   time_sync_regs time_sync_regs_i (
      .sys_clk_i     (sys_clk_i),
      .rst_i         (rst_i),
      .cyc_i         (cyc_i),
      .stb_i         (stb_i),
      .we_i          (we_i),
      .adr_i         (adr_i),
      .dat_i         (dat_i),
      .dat_o         (dat_o),
      .ack_o         (ack_o),
      .tick_time_i   (tick_time),
      .master_time_i (master_time_o),
      .cfg           (cfg_bus.cfg_src)
   );

   tick_timer tick_timer_i (
      .sys_clk_i       (sys_clk_i),
      .rst_i           (rst_i),
      .pps_posedge_i   (pps_posedge_i),
      .pps_negedge_i   (pps_negedge_i),
      .cfg             (cfg_bus.timer_dst),
      .pps_ext_o       (pps_ext),
      .internal_tick_o (internal_tick),
      .pps_o           (pps_o)
   );

   master_clock master_clock_i (
      .sys_clk_i       (sys_clk_i),
      .rst_i           (rst_i),
      .cfg             (cfg_bus.clock_dst),
      .pps_ext_i       (pps_ext),
      .internal_tick_i (internal_tick),
      .sync_rcvd_i     (sync_rcvd),
      .rcvd_time_i     (rcvd_time),
      .master_time_o   (master_time_o),
      .tick_time_o     (tick_time),
      .epoch_o         (epoch_o),
      .int_o           (int_o)
   );

   time_sender time_sender_i (
      .sys_clk_i     (sys_clk_i),
      .rst_i         (rst_i),
      .master_time_i (master_time_o),
      .send_sync_i   (internal_tick),
      .exp_pps_out_o (exp_pps_out_o)
   );

   time_receiver time_receiver_i (
      .sys_clk_i    (sys_clk_i),
      .rst_i        (rst_i),
      .exp_pps_in_i (exp_pps_in_i),
      .rcvd_time_o  (rcvd_time),
      .sync_rcvd_o  (sync_rcvd)
   );

endmodule

/* src/time_sync_cfg_if.sv */
`timescale 1ns/1ps

interface time_sync_cfg_if
   import time_sync_reg_pkg::*;
();
   logic              tick_source;
   logic              tick_int_enable;
   logic              external_sync;
   logic              pps_edge;
   logic [TIME_W-1:0] tick_interval;
   logic [TIME_W-1:0] delta_time;
   // one cycle strobe from a write to the arm address
   logic              arm_sync;

   modport cfg_src (
      output tick_source, tick_int_enable, external_sync, pps_edge,
      output tick_interval, delta_time, arm_sync
   );

   modport timer_dst (
      input tick_source, pps_edge, tick_interval
   );

   modport clock_dst (
      input tick_int_enable, external_sync, delta_time, arm_sync
   );

endinterface

/* src/time_sync_reg_pkg.sv */
package time_sync_reg_pkg;

   // data and address widths of the register bus
   localparam int TIME_W = 32;
   localparam int ADDR_W = 3;

   // word addresses, ARM is write only and the two time words are read only
   localparam logic [ADDR_W-1:0] ADDR_CTRL        = 3'd0;
   localparam logic [ADDR_W-1:0] ADDR_INTERVAL    = 3'd1;
   localparam logic [ADDR_W-1:0] ADDR_DELTA       = 3'd2;
   localparam logic [ADDR_W-1:0] ADDR_ARM         = 3'd3;
   localparam logic [ADDR_W-1:0] ADDR_TICK_TIME   = 3'd4;
   localparam logic [ADDR_W-1:0] ADDR_MASTER_TIME = 3'd5;

   // control word layout
   localparam int CTRL_W            = 4;
   localparam int CTRL_TICK_SRC_BIT = 0;
   localparam int CTRL_INT_EN_BIT   = 1;
   localparam int CTRL_EXT_SYNC_BIT = 2;
   localparam int CTRL_PPS_EDGE_BIT = 3;

   localparam logic [CTRL_W-1:0] CTRL_RESET     = '0;
   localparam logic [TIME_W-1:0] INTERVAL_RESET = 32'd99999;
   localparam logic [TIME_W-1:0] DELTA_RESET    = '0;

   // an epoch starts when this many low bits of master time are zero
   localparam int EPOCH_BITS = 28;

endpackage

/* src/time_sync_regs.sv */
`timescale 1ns/1ps

module time_sync_regs
   import time_sync_reg_pkg::*;
(
   input  logic              sys_clk_i,
   input  logic              rst_i,
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [ADDR_W-1:0] adr_i,
   input  logic [TIME_W-1:0] dat_i,
   output logic [TIME_W-1:0] dat_o,
   output logic              ack_o,
   input  logic [TIME_W-1:0] tick_time_i,
   input  logic [TIME_W-1:0] master_time_i,
   time_sync_cfg_if.cfg_src  cfg
);

   logic              req;
   logic              wr_stb;
   logic [CTRL_W-1:0] ctrl_q;
   logic [TIME_W-1:0] interval_q;
   logic [TIME_W-1:0] delta_q;
   logic              arm_q;
   logic [TIME_W-1:0] rd_data;

   // a request is served once, on the edge that raises ack
   assign req    = cyc_i & stb_i;
   assign wr_stb = req & we_i & ~ack_o;

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= req & ~ack_o;
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (rst_i)
      begin
         ctrl_q     <= CTRL_RESET;
         interval_q <= INTERVAL_RESET;
         delta_q    <= DELTA_RESET;
         arm_q      <= 1'b0;
      end
      else
      begin
         arm_q <= wr_stb && (adr_i == ADDR_ARM);
         if (wr_stb)
         begin
            case (adr_i)
               ADDR_CTRL:     ctrl_q     <= dat_i[CTRL_W-1:0];
               ADDR_INTERVAL: interval_q <= dat_i;
               ADDR_DELTA:    delta_q    <= dat_i;
               default:       ;
            endcase
         end
      end
   end

   // the arm address reads back as zero like any unmapped word
   always_comb
   begin
      case (adr_i)
         ADDR_CTRL:        rd_data = TIME_W'(ctrl_q);
         ADDR_INTERVAL:    rd_data = interval_q;
         ADDR_DELTA:       rd_data = delta_q;
         ADDR_TICK_TIME:   rd_data = tick_time_i;
         ADDR_MASTER_TIME: rd_data = master_time_i;
         default:          rd_data = '0;
      endcase
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (req & ~ack_o)
         dat_o <= rd_data;
   end

   assign cfg.tick_source     = ctrl_q[CTRL_TICK_SRC_BIT];
   assign cfg.tick_int_enable = ctrl_q[CTRL_INT_EN_BIT];
   assign cfg.external_sync   = ctrl_q[CTRL_EXT_SYNC_BIT];
   assign cfg.pps_edge        = ctrl_q[CTRL_PPS_EDGE_BIT];
   assign cfg.tick_interval   = interval_q;
   assign cfg.delta_time      = delta_q;
   assign cfg.arm_sync        = arm_q;

   // a held request must not be acknowledged twice
   ack_single_cycle: assert property (@(posedge sys_clk_i) disable iff (rst_i)
      ack_o |=> !ack_o);

endmodule

/* time_sync.f */
src/time_sync_reg_pkg.sv
src/time_link_pkg.sv
src/time_sync_cfg_if.sv
src/time_sync_regs.sv
src/tick_timer.sv
src/master_clock.sv
src/time_sender.sv
src/time_receiver.sv
src/time_sync.sv
bench/tb_time_sync.sv
